// ==== backendWb.f ====
+incdir+common
common/backendPkg.sv
src/issueDecode.sv
execute/aluUnit.sv
execute/multUnit.sv
execute/csrUnit.sv
src/writeBack.sv
src/completionTable.sv
src/backendWb.sv
verif/backendWb_props.sv
verif/backendWb_tb.sv

// ==== common/backendPkg.sv ====
`include "backend_defs.svh"

package backendPkg;

    typedef enum logic [1:0] {
        OpAlu,
        OpMult,
        OpCsr
    } opClass_t;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSll,
        AluSrl,
        AluSra,
        AluSlt
    } aluOp_t;

    typedef enum logic [1:0] {
        CsrRw,
        CsrSet,
        CsrClr
    } csrOp_t;

    // Zero means no exception.
    typedef enum logic [3:0] {
        ExcNone    = 4'd0,
        ExcIllegal = 4'd2
    } exccode_t;

    typedef logic [$clog2(`ROB_DEPTH)-1:0] robIdx_t;
    typedef logic [$clog2(`PREG_NUM)-1:0]  pregIdx_t;
    typedef logic [$clog2(`CSR_NUM)-1:0]   csrAddr_t;
    typedef logic [`XLEN-1:0]              xData_t;

    typedef struct packed {
        logic     valid;
        opClass_t opClass;
        aluOp_t   aluOp;
        csrOp_t   csrOp;
        csrAddr_t csrAddr;
        pregIdx_t rd;
        robIdx_t  robIdx;
        xData_t   src1;
        xData_t   src2;
    } microOp_t;

    typedef struct packed {
        logic     en;
        logic     we;
        aluOp_t   aluOp;
        pregIdx_t rd;
        robIdx_t  robIdx;
        xData_t   src1;
        xData_t   src2;
        exccode_t exccode;
    } aluCmd_t;

    // The multiplier has a single operation, so no op field.
    typedef struct packed {
        logic     en;
        logic     we;
        pregIdx_t rd;
        robIdx_t  robIdx;
        xData_t   src1;
        xData_t   src2;
        exccode_t exccode;
    } multCmd_t;

    typedef struct packed {
        logic     en;
        logic     we;
        csrOp_t   csrOp;
        csrAddr_t csrAddr;
        pregIdx_t rd;
        robIdx_t  robIdx;
        xData_t   src1;
        exccode_t exccode;
    } csrCmd_t;

    typedef struct packed {
        logic     en;
        logic     we;
        robIdx_t  robIdx;
        pregIdx_t rd;
        xData_t   res;
        exccode_t exccode;
    } wbData_t;

    typedef wbData_t [`ALU_SIZE+`LSU_SIZE-1:0] wbBus_t;

endpackage

// ==== common/backend_defs.svh ====
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

// The issue and ALU lanes also form the first rows of the writeback bus.
`define ALU_SIZE 3
// The load result lanes follow the ALU rows on the bus.
`define LSU_SIZE 1
`define MULT_SIZE 1

// Nonzero when the multiplier is present. It then shares lane 2 of the bus.
`define EXT_M 1

`define XLEN 32
`define ROB_DEPTH 16
`define PREG_NUM 64
`define CSR_NUM 8

`endif

// ==== execute/aluUnit.sv ====
`timescale 1ns/1ps
`include "backend_defs.svh"

module aluUnit
    import backendPkg::*;
(
    input  aluCmd_t cmd,
    output wbData_t result
);
    logic [4:0]       shamt;
    logic [`XLEN-1:0] aluOut;

    assign shamt = cmd.src2[4:0];

    always_comb begin
        case (cmd.aluOp)
            AluAdd: aluOut = cmd.src1 + cmd.src2;
            AluSub: aluOut = cmd.src1 - cmd.src2;
            AluAnd: aluOut = cmd.src1 & cmd.src2;
            AluOr:  aluOut = cmd.src1 | cmd.src2;
            AluXor: aluOut = cmd.src1 ^ cmd.src2;
            AluSll: aluOut = cmd.src1 << shamt;
            AluSrl: aluOut = cmd.src1 >> shamt;
            AluSra: aluOut = $signed(cmd.src1) >>> shamt;
            AluSlt: begin
                aluOut    = '0;
                aluOut[0] = $signed(cmd.src1) < $signed(cmd.src2);
            end
            default: aluOut = '0;
        endcase
    end

    // A faulting op carries no data, only its exception code.
    assign result.en      = cmd.en;
    assign result.we      = cmd.we;
    assign result.robIdx  = cmd.robIdx;
    assign result.rd      = cmd.rd;
    assign result.res     = (cmd.exccode != ExcNone) ? '0 : aluOut;
    assign result.exccode = cmd.exccode;

endmodule

// ==== execute/csrUnit.sv ====
`timescale 1ns/1ps
`include "backend_defs.svh"

module csrUnit
    import backendPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  csrCmd_t cmd,
    output wbData_t result
);
    logic [`XLEN-1:0] csrRegs [`CSR_NUM];
    logic [`XLEN-1:0] oldVal;
    logic [`XLEN-1:0] newVal;
    logic             csrWr;

    assign oldVal = csrRegs[cmd.csrAddr];
    assign csrWr  = cmd.en && (cmd.exccode == ExcNone);

    always_comb begin
        case (cmd.csrOp)
            CsrRw:   newVal = cmd.src1;
            CsrSet:  newVal = oldVal | cmd.src1;
            CsrClr:  newVal = oldVal & ~cmd.src1;
            default: newVal = oldVal;
        endcase
    end

    // The old value goes back to rd while the new one is written.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `CSR_NUM; i++) begin
                csrRegs[i] <= '0;
            end
            result <= '0;
        end else begin
            if (csrWr) begin
                csrRegs[cmd.csrAddr] <= newVal;
            end
            result <= '{en: cmd.en, we: cmd.we, robIdx: cmd.robIdx, rd: cmd.rd,
                        res: oldVal, exccode: cmd.exccode};
        end
    end

endmodule

// ==== execute/multUnit.sv ====
`timescale 1ns/1ps
`include "backend_defs.svh"

module multUnit
    import backendPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  multCmd_t cmd,
    output wbData_t  result
);
    localparam int Half = `XLEN / 2;

    logic             s1En;
    logic             s1We;
    pregIdx_t         s1Rd;
    robIdx_t          s1RobIdx;
    exccode_t         s1Exc;
    logic [`XLEN-1:0] s1PartLo;
    logic [Half-1:0]  s1PartHi;
    wbData_t          resQ;

    // Stage 1 forms two partial products. Only the low word of the full
    // product is kept, so the upper half needs just its low Half bits.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1En <= 1'b0;
        end else begin
            s1En <= cmd.en;
        end
    end

    always_ff @(posedge clk) begin
        s1We     <= cmd.we;
        s1Rd     <= cmd.rd;
        s1RobIdx <= cmd.robIdx;
        s1Exc    <= cmd.exccode;
        s1PartLo <= cmd.src1[Half-1:0] * cmd.src2;
        s1PartHi <= cmd.src1[`XLEN-1:Half] * cmd.src2[Half-1:0];
    end

    // Stage 2 sums the shifted partial products.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resQ <= '0;
        end else begin
            resQ <= '{en: s1En, we: s1We, robIdx: s1RobIdx, rd: s1Rd,
                      res: s1PartLo + {s1PartHi, {Half{1'b0}}},
                      exccode: s1Exc};
        end
    end

    assign result = resQ;

endmodule

// ==== src/backendWb.sv ====
`timescale 1ns/1ps
`include "backend_defs.svh"

module backendWb
    import backendPkg::*;
(
    input  logic                      clk,
    input  logic                      rstN,
    input  microOp_t [`ALU_SIZE-1:0]  issue,
    input  wbData_t  [`LSU_SIZE-1:0]  lsuRes,
    input  logic                      robAlloc,
    input  robIdx_t                   allocIdx,
    output wbBus_t                    wbBus,
    output logic [`ROB_DEPTH-1:0]     doneMask,
    output logic [`ROB_DEPTH-1:0]     excMask
);
    aluCmd_t [`ALU_SIZE-1:0] aluCmd;
    csrCmd_t                 csrCmd;
    multCmd_t                multCmd;
    wbData_t [`ALU_SIZE-1:0] aluRes;
    wbData_t                 csrRes;
    wbData_t                 multRes;

    issueDecode issueDecode_i (
        .clk, .rstN, .issue, .aluCmd, .csrCmd, .multCmd
    );

    for (genvar i = 0; i < `ALU_SIZE; i++) begin : gAlu
        aluUnit aluUnit_i (
            .cmd    (aluCmd[i]),
            .result (aluRes[i])
        );
    end

    multUnit multUnit_i (
        .clk, .rstN, .cmd(multCmd), .result(multRes)
    );

    csrUnit csrUnit_i (
        .clk, .rstN, .cmd(csrCmd), .result(csrRes)
    );

    writeBack writeBack_i (
        .clk, .rstN, .aluRes, .csrRes, .multRes, .lsuRes, .wbBus
    );

    completionTable completionTable_i (
        .clk, .rstN, .wbBus, .robAlloc, .allocIdx, .doneMask, .excMask
    );

endmodule

// ==== src/completionTable.sv ====
`timescale 1ns/1ps
`include "backend_defs.svh"

module completionTable
    import backendPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  wbBus_t                wbBus,
    input  logic                  robAlloc,
    input  robIdx_t               allocIdx,
    output logic [`ROB_DEPTH-1:0] doneMask,
    output logic [`ROB_DEPTH-1:0] excMask
);
    localparam int BusRows = `ALU_SIZE + `LSU_SIZE;

    logic [`ROB_DEPTH-1:0] doneNext;
    logic [`ROB_DEPTH-1:0] excNext;

    always_comb begin
        doneNext = doneMask;
        excNext  = excMask;
        for (int r = 0; r < BusRows; r++) begin
            if (wbBus[r].en) begin
                doneNext[wbBus[r].robIdx] = 1'b1;
                if (wbBus[r].exccode != ExcNone) begin
                    excNext[wbBus[r].robIdx] = 1'b1;
                end
            end
        end
        // A new allocation wins over a late completion of the old entry.
        if (robAlloc) begin
            doneNext[allocIdx] = 1'b0;
            excNext[allocIdx]  = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            doneMask <= '0;
            excMask  <= '0;
        end else begin
            doneMask <= doneNext;
            excMask  <= excNext;
        end
    end

endmodule

// ==== src/issueDecode.sv ====
`timescale 1ns/1ps
`include "backend_defs.svh"

module issueDecode
    import backendPkg::*;
(
    input  logic                      clk,
    input  logic                      rstN,
    input  microOp_t [`ALU_SIZE-1:0]  issue,
    output aluCmd_t  [`ALU_SIZE-1:0]  aluCmd,
    output csrCmd_t                   csrCmd,
    output multCmd_t                  multCmd
);
    localparam int CsrLane  = 0;
    localparam int MultLane = 2;
    localparam bit HasMult  = (`EXT_M != 0);

    aluCmd_t [`ALU_SIZE-1:0] aluNext;
    csrCmd_t                 csrNext;
    multCmd_t                multNext;

    // ----------------------------------------------------------------------
    // Routing by class and lane
    // ----------------------------------------------------------------------
    always_comb begin
        csrNext  = '0;
        multNext = '0;
        for (int i = 0; i < `ALU_SIZE; i++) begin
            aluNext[i]        = '0;
            aluNext[i].aluOp  = issue[i].aluOp;
            aluNext[i].rd     = issue[i].rd;
            aluNext[i].robIdx = issue[i].robIdx;
            aluNext[i].src1   = issue[i].src1;
            aluNext[i].src2   = issue[i].src2;
            if (issue[i].valid) begin
                if (issue[i].opClass == OpAlu) begin
                    aluNext[i].en = 1'b1;
                    aluNext[i].we = issue[i].rd != '0;
                end else if (issue[i].opClass == OpCsr && i == CsrLane) begin
                    csrNext = '{en: 1'b1, we: issue[i].rd != '0,
                                csrOp: issue[i].csrOp, csrAddr: issue[i].csrAddr,
                                rd: issue[i].rd, robIdx: issue[i].robIdx,
                                src1: issue[i].src1, exccode: ExcNone};
                end else if (issue[i].opClass == OpMult && i == MultLane && HasMult) begin
                    multNext = '{en: 1'b1, we: issue[i].rd != '0,
                                 rd: issue[i].rd, robIdx: issue[i].robIdx,
                                 src1: issue[i].src1, src2: issue[i].src2,
                                 exccode: ExcNone};
                end else begin
                    // A wrong-lane op retires through the ALU path as an illegal op.
                    aluNext[i].en      = 1'b1;
                    aluNext[i].exccode = ExcIllegal;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aluCmd  <= '0;
            csrCmd  <= '0;
            multCmd <= '0;
        end else begin
            aluCmd  <= aluNext;
            csrCmd  <= csrNext;
            multCmd <= multNext;
        end
    end

endmodule

// ==== src/writeBack.sv ====
`timescale 1ns/1ps
`include "backend_defs.svh"

module writeBack
    import backendPkg::*;
(
    input  logic                     clk,
    input  logic                     rstN,
    input  wbData_t [`ALU_SIZE-1:0]  aluRes,
    input  wbData_t                  csrRes,
    input  wbData_t                  multRes,
    input  wbData_t [`LSU_SIZE-1:0]  lsuRes,
    output wbBus_t                   wbBus
);
    localparam int CsrRow  = 0;
    localparam int MultRow = 2;
    localparam bit HasMult = (`EXT_M != 0);

    wbData_t [`ALU_SIZE-1:0] aluQ;
    wbData_t                 csrQ;
    wbData_t                 multQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aluQ  <= '0;
            csrQ  <= '0;
            multQ <= '0;
        end else begin
            aluQ  <= aluRes;
            csrQ  <= csrRes;
            multQ <= multRes;
        end
    end

    // ----------------------------------------------------------------------
    // ALU rows shared with the CSR unit and the multiplier
    // ----------------------------------------------------------------------
    // The issuer keeps the shared units off a row in the cycles its ALU
    // lane writes back, so a plain priority mux is enough.
    for (genvar i = 0; i < `ALU_SIZE; i++) begin : gAluRow
        if (i == CsrRow) begin : gCsr
            assign wbBus[i] = csrQ.en ? csrQ : aluQ[i];
        end else if (i == MultRow && HasMult) begin : gMult
            assign wbBus[i] = multQ.en ? multQ : aluQ[i];
        end else begin : gPlain
            assign wbBus[i] = aluQ[i];
        end
    end

    // ----------------------------------------------------------------------
    // Load rows
    // ----------------------------------------------------------------------
    // Loads arrive already timed by the load unit and pass straight through.
    for (genvar i = 0; i < `LSU_SIZE; i++) begin : gLsuRow
        assign wbBus[`ALU_SIZE+i] = '{
            en:      lsuRes[i].en,
            we:      lsuRes[i].rd != '0,
            robIdx:  lsuRes[i].robIdx,
            rd:      lsuRes[i].rd,
            res:     lsuRes[i].res,
            exccode: lsuRes[i].exccode
        };
    end

endmodule

// ==== verif/backendWb_props.sv ====
`timescale 1ns/1ps
`include "backend_defs.svh"

module backendWb_props
    import backendPkg::*;
(
    input logic                    clk,
    input logic                    rstN,
    input wbBus_t                  wbBus,
    input wbData_t [`ALU_SIZE-1:0] aluRes,
    input wbData_t                 csrRes,
    input wbData_t                 multRes,
    input logic                    robAlloc,
    input robIdx_t                 allocIdx,
    input logic [`ROB_DEPTH-1:0]   doneMask
);
    localparam int Rows = `ALU_SIZE + `LSU_SIZE;

    int unsigned failCount = 0;

    // The shared unit and its ALU lane are registered into writeback on the
    // same edge, so both enables together means a lost result.
    csrAluCollision: assert property (
        @(posedge clk) disable iff (!rstN) !(csrRes.en && aluRes[0].en)
    ) else begin
        $error("CSR and ALU lane 0 results collide on row 0");
        failCount++;
    end

    multAluCollision: assert property (
        @(posedge clk) disable iff (!rstN) !(multRes.en && aluRes[2].en)
    ) else begin
        $error("Multiplier and ALU lane 2 results collide on row 2");
        failCount++;
    end

    for (genvar r = 0; r < Rows; r++) begin : gRow
        weNeedsRd: assert property (
            @(posedge clk) disable iff (!rstN)
            wbBus[r].en |-> !(wbBus[r].we && wbBus[r].rd == '0)
        ) else begin
            $error("Row %0d writes back with rd zero", r);
            failCount++;
        end

        doneFollowsWb: assert property (
            @(posedge clk) disable iff (!rstN)
            wbBus[r].en && !(robAlloc && allocIdx == wbBus[r].robIdx)
                |=> doneMask[$past(wbBus[r].robIdx)]
        ) else begin
            $error("Row %0d completion did not set its done bit", r);
            failCount++;
        end
    end

endmodule

// ==== verif/backendWb_tb.sv ====
`timescale 1ns/1ps
`include "backend_defs.svh"

module backendWb_tb
    import backendPkg::*;
();
    localparam int Rows     = `ALU_SIZE + `LSU_SIZE;
    localparam int ResetCyc = 10;
    localparam int AluOps   = 24;
    localparam int MultOps  = 8;
    localparam int CsrOps   = 8;
    localparam int LoadOps  = 8;
    localparam int Drain    = 6;
    localparam int TimeoutCycles = ResetCyc + AluOps + MultOps + CsrOps + LoadOps + 2
                                   + (4 + `ROB_DEPTH) + 6 * Drain + 20;

    logic                     clk = 1'b0;
    logic                     rstN;
    microOp_t [`ALU_SIZE-1:0] issue;
    wbData_t  [`LSU_SIZE-1:0] lsuRes;
    logic                     robAlloc;
    robIdx_t                  allocIdx;
    wbBus_t                   wbBus;
    logic [`ROB_DEPTH-1:0]    doneMask;
    logic [`ROB_DEPTH-1:0]    excMask;

    logic [31:0]           lfsr = 32'hd9ce;
    wbData_t               expRow [8][Rows];
    logic                  expSet [8][Rows];
    xData_t                csrModel [`CSR_NUM];
    logic [`ROB_DEPTH-1:0] expDone;
    logic [`ROB_DEPTH-1:0] expExc;
    int cyc = 0;
    int checks = 0;
    int errors = 0;
    int testErrors = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int waitCyc = 0;

    backendWb backendWb_i (
        .clk, .rstN, .issue, .lsuRes, .robAlloc, .allocIdx, .wbBus, .doneMask, .excMask
    );

    bind backendWb backendWb_props props_i (
        .clk, .rstN, .wbBus, .aluRes, .csrRes, .multRes, .robAlloc, .allocIdx, .doneMask
    );

    always #10 clk = ~clk;

    // ----------------------------------------------------------------------
    // Stimulus and reference model
    // ----------------------------------------------------------------------
    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic xData_t aluModel(aluOp_t op, xData_t a, xData_t b);
        case (op)
            AluAdd:  return a + b;
            AluSub:  return a - b;
            AluAnd:  return a & b;
            AluOr:   return a | b;
            AluXor:  return a ^ b;
            AluSll:  return a << b[4:0];
            AluSrl:  return a >> b[4:0];
            AluSra:  return $signed(a) >>> b[4:0];
            AluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic microOp_t makeOp(opClass_t cls, aluOp_t aop, csrOp_t cop, csrAddr_t ca,
                                        pregIdx_t rd, robIdx_t rob, xData_t s1, xData_t s2);
        return '{valid: 1'b1, opClass: cls, aluOp: aop, csrOp: cop, csrAddr: ca,
                 rd: rd, robIdx: rob, src1: s1, src2: s2};
    endfunction

    // Delay counts falling edges from the one that drove the micro-op.
    task automatic scheduleRow(int row, int delay, logic we, robIdx_t rob, pregIdx_t rd,
                               xData_t res, exccode_t exc);
        int slot;
        slot = (cyc + delay) % 8;
        expSet[slot][row] = 1'b1;
        expRow[slot][row] = '{en: 1'b1, we: we, robIdx: rob, rd: rd, res: res, exccode: exc};
    endtask

    task automatic checkBus();
        int slot;
        slot = cyc % 8;
        for (int r = 0; r < Rows; r++) begin
            checks++;
            if (expSet[slot][r]) begin
                assert (wbBus[r] === expRow[slot][r]) else begin
                    $display("Fail %0t wbBus[%0d]: got %h, expected %h",
                             $time, r, wbBus[r], expRow[slot][r]);
                    testErrors++;
                end
                expDone[expRow[slot][r].robIdx] = 1'b1;
                if (expRow[slot][r].exccode != ExcNone) begin
                    expExc[expRow[slot][r].robIdx] = 1'b1;
                end
            end else begin
                assert (wbBus[r].en === 1'b0) else begin
                    $display("Fail %0t wbBus[%0d].en: got %b, expected 0",
                             $time, r, wbBus[r].en);
                    testErrors++;
                end
            end
            expSet[slot][r] = 1'b0;
        end
    endtask

    task automatic checkMasks();
        checks += 2;
        assert (doneMask === expDone) else begin
            $display("Fail %0t doneMask: got %h, expected %h", $time, doneMask, expDone);
            testErrors++;
        end
        assert (excMask === expExc) else begin
            $display("Fail %0t excMask: got %h, expected %h", $time, excMask, expExc);
            testErrors++;
        end
    endtask

    // Checks the outputs on the falling edge, then returns all inputs to idle.
    task automatic step();
        @(negedge clk);
        cyc++;
        checkBus();
        issue    = '0;
        lsuRes   = '0;
        robAlloc = 1'b0;
        allocIdx = '0;
    endtask

    task automatic endTest(string name);
        repeat (Drain) step();
        testsRun++;
        errors += testErrors;
        if (testErrors == 0) begin
            $display("Test %s: ok", name);
        end else begin
            testsFailed++;
            $display("Test %s: %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    initial begin
        aluOp_t      aop;
        csrOp_t      cop;
        csrAddr_t    ca;
        pregIdx_t    rd;
        robIdx_t     rob;
        xData_t      s1;
        xData_t      s2;
        xData_t      old;
        logic [63:0] prod;
        rstN     = 1'b0;
        issue    = '0;
        lsuRes   = '0;
        robAlloc = 1'b0;
        allocIdx = '0;
        expDone  = '0;
        expExc   = '0;
        foreach (expSet[s, r]) begin
            expSet[s][r] = 1'b0;
        end
        foreach (csrModel[i]) begin
            csrModel[i] = '0;
        end
        repeat (ResetCyc) @(negedge clk);
        rstN = 1'b1;

        for (int n = 0; n < AluOps; n++) begin
            step();
            for (int l = 0; l < `ALU_SIZE; l++) begin
                aop = aluOp_t'(randBits(4) % 9);
                rd  = (n % 5 == l) ? '0 : pregIdx_t'(randBits(6));
                rob = robIdx_t'(randBits(4));
                s1  = randBits(32);
                s2  = randBits(32);
                issue[l] = makeOp(OpAlu, aop, CsrRw, '0, rd, rob, s1, s2);
                scheduleRow(l, 2, rd != '0, rob, rd, aluModel(aop, s1, s2), ExcNone);
            end
        end
        endTest("alu lanes");

        for (int n = 0; n < MultOps; n++) begin
            step();
            rd   = pregIdx_t'(randBits(6));
            rob  = robIdx_t'(randBits(4));
            s1   = randBits(32);
            s2   = randBits(32);
            prod = {32'd0, s1} * {32'd0, s2};
            issue[2] = makeOp(OpMult, AluAdd, CsrRw, '0, rd, rob, s1, s2);
            scheduleRow(2, 4, rd != '0, rob, rd, prod[31:0], ExcNone);
        end
        endTest("multiply");

        // Write, set, clear, then a set with zero that only reads.
        for (int n = 0; n < CsrOps; n++) begin
            step();
            ca  = (n < 4) ? csrAddr_t'(3) : csrAddr_t'(5);
            cop = csrOp_t'((n % 4 == 3) ? 1 : n % 4);
            s1  = (n % 4 == 3) ? '0 : randBits(32);
            rd  = pregIdx_t'(randBits(6));
            rob = robIdx_t'(randBits(4));
            old = csrModel[ca];
            case (cop)
                CsrRw:   csrModel[ca] = s1;
                CsrSet:  csrModel[ca] = old | s1;
                default: csrModel[ca] = old & ~s1;
            endcase
            issue[0] = makeOp(OpCsr, AluAdd, cop, ca, rd, rob, s1, '0);
            scheduleRow(0, 3, rd != '0, rob, rd, old, ExcNone);
        end
        endTest("csr");

        for (int n = 0; n < LoadOps; n++) begin
            step();
            rd  = (n % 3 == 0) ? '0 : pregIdx_t'(randBits(6));
            rob = robIdx_t'(randBits(4));
            s1  = randBits(32);
            lsuRes[0] = '{en: 1'b1, we: 1'b1, robIdx: rob, rd: rd, res: s1, exccode: ExcNone};
            scheduleRow(`ALU_SIZE, 1, rd != '0, rob, rd, s1, ExcNone);
        end
        endTest("load rows");

        step();
        issue[1] = makeOp(OpCsr, AluAdd, CsrSet, 3'd1, 6'd7, 4'd9, randBits(32), '0);
        scheduleRow(1, 2, 1'b0, 4'd9, 6'd7, '0, ExcIllegal);
        step();
        issue[1] = makeOp(OpMult, AluAdd, CsrRw, '0, 6'd8, 4'd10, randBits(32), randBits(32));
        scheduleRow(1, 2, 1'b0, 4'd10, 6'd8, '0, ExcIllegal);
        endTest("wrong lane");

        checkMasks();
        // Entry 4 completes on the same edge that reallocates it.
        step();
        issue[0] = makeOp(OpAlu, AluAdd, CsrRw, '0, 6'd1, 4'd4, 32'd1, 32'd2);
        scheduleRow(0, 2, 1'b1, 4'd4, 6'd1, 32'd3, ExcNone);
        step();
        step();
        robAlloc   = 1'b1;
        allocIdx   = 4'd4;
        expDone[4] = 1'b0;
        expExc[4]  = 1'b0;
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            step();
            checkMasks();
            robAlloc   = 1'b1;
            allocIdx   = robIdx_t'(k);
            expDone[k] = 1'b0;
            expExc[k]  = 1'b0;
        end
        step();
        checkMasks();
        endTest("completion masks");

        errors += backendWb_i.props_i.failCount;
        $display("Tests: %0d run, %0d failed; checks: %0d; errors: %0d",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        while (waitCyc < TimeoutCycles) begin
            @(posedge clk);
            waitCyc++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
        $display("Simulation failed");
        $finish;
    end

endmodule
